// File: verilog/periph_map_pkg.sv
/*
 * Peripheral address map: bus widths, peripheral selects, register offsets
 * and the two views of a bus address word
 */
`default_nettype none

package periph_map_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = 4;
  localparam int OFF_W  = 6;

  localparam logic [SEL_W-1:0] PLIC_IDX = 4'd0;
  localparam logic [SEL_W-1:0] GPIO_IDX = 4'd1;

  localparam logic [OFF_W-1:0] GPIO_IN_OFF  = 6'd0;
  localparam logic [OFF_W-1:0] GPIO_OUT_OFF = 6'd1;
  localparam logic [OFF_W-1:0] GPIO_EN_OFF  = 6'd2;
  localparam logic [OFF_W-1:0] GPIO_IE_OFF  = 6'd3;
  localparam logic [OFF_W-1:0] GPIO_IS_OFF  = 6'd4;

  localparam logic [OFF_W-1:0] PLIC_PEND_OFF  = 6'd0;
  localparam logic [OFF_W-1:0] PLIC_ENA_OFF   = 6'd1;
  localparam logic [OFF_W-1:0] PLIC_CLAIM_OFF = 6'd2;
  localparam logic [OFF_W-1:0] PLIC_MSIP_OFF  = 6'd3;

  typedef struct packed {
    logic [ADDR_W-SEL_W-OFF_W-3:0] unused;
    logic [SEL_W-1:0]              sel;
    logic [OFF_W-1:0]              off;
    logic [1:0]                    byte_off;
  } periph_addr_s;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    periph_addr_s      fields;
  } periph_addr_u;

endpackage

`default_nettype wire

// File: verilog/irq_pkg.sv
/*
 * Interrupt source layout and claim ID width of the interrupt controller
 */
`default_nettype none

package irq_pkg;

  // Source 0 is reserved and reads as no interrupt
  localparam int GPIO_SRC_BASE = 1;

  // External sources follow right after the GPIO pins
  localparam int MAX_SRC = 32;

  localparam int ID_W = 5;

endpackage

`default_nettype wire

// File: verilog/periph_reg_bridge.sv
/*
 * OBI slave to register bridge: decodes the word address into a peripheral
 * strobe and offset, and returns read data one cycle after each request
 */
`timescale 1ns/1ps
`default_nettype none

module periph_reg_bridge (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               obi_req_i,
  input  logic                               obi_we_i,
  input  logic [3:0]                         obi_be_i,
  input  logic [periph_map_pkg::ADDR_W-1:0]  obi_addr_i,
  input  logic [periph_map_pkg::DATA_W-1:0]  obi_wdata_i,
  output logic                               obi_gnt_o,
  output logic                               obi_rvalid_o,
  output logic [periph_map_pkg::DATA_W-1:0]  obi_rdata_o,
  output logic [periph_map_pkg::OFF_W-1:0]   reg_off_o,
  output logic [periph_map_pkg::DATA_W-1:0]  reg_wdata_o,
  output logic                               gpio_we_o,
  output logic                               gpio_re_o,
  output logic                               plic_we_o,
  output logic                               plic_re_o,
  input  logic [periph_map_pkg::DATA_W-1:0]  gpio_rdata_i,
  input  logic [periph_map_pkg::DATA_W-1:0]  plic_rdata_i
);

  import periph_map_pkg::*;

  periph_addr_u addr;
  logic         gpio_sel;
  logic         plic_sel;

  assign addr.raw = obi_addr_i;
  assign gpio_sel = (addr.fields.sel == GPIO_IDX);
  assign plic_sel = (addr.fields.sel == PLIC_IDX);

  // Every access is a full word, byte enables play no part
  assign obi_gnt_o   = 1'b1;
  assign reg_off_o   = addr.fields.off;
  assign reg_wdata_o = obi_wdata_i;

  assign gpio_we_o = obi_req_i & obi_we_i & gpio_sel;
  assign gpio_re_o = obi_req_i & ~obi_we_i & gpio_sel;
  assign plic_we_o = obi_req_i & obi_we_i & plic_sel;
  assign plic_re_o = obi_req_i & ~obi_we_i & plic_sel;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      obi_rvalid_o <= 1'b0;
      obi_rdata_o  <= '0;
    end else begin
      obi_rvalid_o <= obi_req_i;
      // Unmapped reads and all writes answer with zero
      if (obi_req_i) begin
        if (gpio_re_o) begin
          obi_rdata_o <= gpio_rdata_i;
        end else if (plic_re_o) begin
          obi_rdata_o <= plic_rdata_i;
        end else begin
          obi_rdata_o <= '0;
        end
      end
    end
  end

  a_single_strobe : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({gpio_we_o, gpio_re_o, plic_we_o, plic_re_o}));

endmodule

`default_nettype wire

// File: verilog/gpio_port.sv
/*
 * GPIO port: output and enable registers, three-stage input synchroniser
 * and rising-edge interrupt status with write-one-to-clear
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_port #(
  parameter int GPIO_W = 24
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [periph_map_pkg::OFF_W-1:0]  reg_off_i,
  input  logic [periph_map_pkg::DATA_W-1:0] reg_wdata_i,
  input  logic                              we_i,
  input  logic                              re_i,
  output logic [periph_map_pkg::DATA_W-1:0] rdata_o,
  input  logic [GPIO_W-1:0]                 gpio_i,
  output logic [GPIO_W-1:0]                 gpio_o,
  output logic [GPIO_W-1:0]                 gpio_en_o,
  output logic [GPIO_W-1:0]                 irq_o
);

  import periph_map_pkg::*;

  logic [GPIO_W-1:0] sync1_q;
  logic [GPIO_W-1:0] sync2_q;
  logic [GPIO_W-1:0] sync3_q;
  logic [GPIO_W-1:0] out_q;
  logic [GPIO_W-1:0] en_q;
  logic [GPIO_W-1:0] ie_q;
  logic [GPIO_W-1:0] is_q;
  logic [GPIO_W-1:0] rise;
  logic [GPIO_W-1:0] is_clr;

  // Edge seen between the last two synchroniser stages
  assign rise   = sync2_q & ~sync3_q;
  assign is_clr = (we_i && reg_off_i == GPIO_IS_OFF) ? reg_wdata_i[GPIO_W-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      sync3_q <= '0;
      out_q   <= '0;
      en_q    <= '0;
      ie_q    <= '0;
      is_q    <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      sync3_q <= sync2_q;
      // A new edge wins over a clear in the same cycle
      is_q    <= (is_q & ~is_clr) | rise;
      if (we_i) begin
        case (reg_off_i)
          GPIO_OUT_OFF: out_q <= reg_wdata_i[GPIO_W-1:0];
          GPIO_EN_OFF:  en_q  <= reg_wdata_i[GPIO_W-1:0];
          GPIO_IE_OFF:  ie_q  <= reg_wdata_i[GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (re_i) begin
      case (reg_off_i)
        GPIO_IN_OFF:  rdata_o = DATA_W'(sync2_q);
        GPIO_OUT_OFF: rdata_o = DATA_W'(out_q);
        GPIO_EN_OFF:  rdata_o = DATA_W'(en_q);
        GPIO_IE_OFF:  rdata_o = DATA_W'(ie_q);
        GPIO_IS_OFF:  rdata_o = DATA_W'(is_q);
        default:      rdata_o = '0;
      endcase
    end
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = en_q;
  assign irq_o     = is_q & ie_q;

endmodule

`default_nettype wire

// File: verilog/plic_lite.sv
/*
 * Small platform interrupt controller: pending and enable per source,
 * lowest-ID claim read and a software interrupt bit
 */
`timescale 1ns/1ps
`default_nettype none

module plic_lite #(
  parameter int GPIO_W      = 24,
  parameter int NUM_EXT_IRQ = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic [periph_map_pkg::OFF_W-1:0]  reg_off_i,
  input  logic [periph_map_pkg::DATA_W-1:0] reg_wdata_i,
  input  logic                              we_i,
  input  logic                              re_i,
  output logic [periph_map_pkg::DATA_W-1:0] rdata_o,
  input  logic [GPIO_W-1:0]                 gpio_irq_i,
  input  logic [NUM_EXT_IRQ-1:0]            irq_ext_i,
  output logic                              irq_o,
  output logic                              msip_o
);

  import periph_map_pkg::*;
  import irq_pkg::*;

  localparam int NUM_SRC = 1 + GPIO_W + NUM_EXT_IRQ;

  if (NUM_SRC > MAX_SRC) begin : g_src_check
    $error("plic_lite: too many interrupt sources");
  end

  logic [NUM_SRC-1:0] src;
  logic [NUM_SRC-1:0] pend_q;
  logic [NUM_SRC-1:0] pend_d;
  logic [NUM_SRC-1:0] ena_q;
  logic [NUM_SRC-1:0] active;
  logic [ID_W-1:0]    claim_id;
  logic               msip_q;
  logic               claim_rd;

  assign src[0] = 1'b0;
  assign src[GPIO_SRC_BASE +: GPIO_W] = gpio_irq_i;
  assign src[GPIO_SRC_BASE + GPIO_W +: NUM_EXT_IRQ] = irq_ext_i;

  assign active   = pend_q & ena_q;
  assign claim_rd = re_i && (reg_off_i == PLIC_CLAIM_OFF);

  // Lowest pending and enabled ID, zero when idle
  always_comb begin
    claim_id = '0;
    for (int i = NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) begin
        claim_id = ID_W'(i);
      end
    end
  end

  always_comb begin
    pend_d = pend_q | src;
    if (claim_rd) begin
      pend_d[claim_id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= '0;
      ena_q  <= '0;
      msip_q <= 1'b0;
    end else begin
      pend_q <= pend_d;
      if (we_i) begin
        case (reg_off_i)
          // Source 0 can never be enabled
          PLIC_ENA_OFF:  ena_q  <= reg_wdata_i[NUM_SRC-1:0] & ~NUM_SRC'(1);
          PLIC_MSIP_OFF: msip_q <= reg_wdata_i[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    if (re_i) begin
      case (reg_off_i)
        PLIC_PEND_OFF:  rdata_o = DATA_W'(pend_q);
        PLIC_ENA_OFF:   rdata_o = DATA_W'(ena_q);
        PLIC_CLAIM_OFF: rdata_o = DATA_W'(claim_id);
        PLIC_MSIP_OFF:  rdata_o = DATA_W'(msip_q);
        default:        rdata_o = '0;
      endcase
    end
  end

  assign irq_o  = |active;
  assign msip_o = msip_q;

  a_irq_has_id : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    irq_o |-> claim_id != '0);

endmodule

`default_nettype wire

// File: verilog/peripheral_subsystem.sv
/*
 * Peripheral subsystem: OBI register bridge feeding a GPIO port and
 * an interrupt controller
 */
`timescale 1ns/1ps
`default_nettype none

module peripheral_subsystem #(
  parameter int GPIO_W      = 24,
  parameter int NUM_EXT_IRQ = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              obi_req_i,
  input  logic                              obi_we_i,
  input  logic [3:0]                        obi_be_i,
  input  logic [periph_map_pkg::ADDR_W-1:0] obi_addr_i,
  input  logic [periph_map_pkg::DATA_W-1:0] obi_wdata_i,
  output logic                              obi_gnt_o,
  output logic                              obi_rvalid_o,
  output logic [periph_map_pkg::DATA_W-1:0] obi_rdata_o,
  input  logic [GPIO_W-1:0]                 gpio_i,
  output logic [GPIO_W-1:0]                 gpio_o,
  output logic [GPIO_W-1:0]                 gpio_en_o,
  input  logic [NUM_EXT_IRQ-1:0]            irq_ext_i,
  output logic                              irq_o,
  output logic                              msip_o
);

  import periph_map_pkg::*;

  logic [OFF_W-1:0]  reg_off;
  logic [DATA_W-1:0] reg_wdata;
  logic [DATA_W-1:0] gpio_rdata;
  logic [DATA_W-1:0] plic_rdata;
  logic              gpio_we;
  logic              gpio_re;
  logic              plic_we;
  logic              plic_re;
  logic [GPIO_W-1:0] gpio_irq;

  periph_reg_bridge bridge_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .obi_req_i    (obi_req_i),
    .obi_we_i     (obi_we_i),
    .obi_be_i     (obi_be_i),
    .obi_addr_i   (obi_addr_i),
    .obi_wdata_i  (obi_wdata_i),
    .obi_gnt_o    (obi_gnt_o),
    .obi_rvalid_o (obi_rvalid_o),
    .obi_rdata_o  (obi_rdata_o),
    .reg_off_o    (reg_off),
    .reg_wdata_o  (reg_wdata),
    .gpio_we_o    (gpio_we),
    .gpio_re_o    (gpio_re),
    .plic_we_o    (plic_we),
    .plic_re_o    (plic_re),
    .gpio_rdata_i (gpio_rdata),
    .plic_rdata_i (plic_rdata)
  );

  gpio_port #(
    .GPIO_W (GPIO_W)
  ) gpio_i_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_off_i   (reg_off),
    .reg_wdata_i (reg_wdata),
    .we_i        (gpio_we),
    .re_i        (gpio_re),
    .rdata_o     (gpio_rdata),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .irq_o       (gpio_irq)
  );

  plic_lite #(
    .GPIO_W      (GPIO_W),
    .NUM_EXT_IRQ (NUM_EXT_IRQ)
  ) plic_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_off_i   (reg_off),
    .reg_wdata_i (reg_wdata),
    .we_i        (plic_we),
    .re_i        (plic_re),
    .rdata_o     (plic_rdata),
    .gpio_irq_i  (gpio_irq),
    .irq_ext_i   (irq_ext_i),
    .irq_o       (irq_o),
    .msip_o      (msip_o)
  );

endmodule

`default_nettype wire

// File: verification/subsystem_checker.sv
/*
 * Cycle model of the peripheral subsystem that compares read data,
 * pins and interrupt lines with the DUT
 */
`timescale 1ns/1ps
`default_nettype none

module subsystem_checker #(
  parameter int GPIO_W      = 24,
  parameter int NUM_EXT_IRQ = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   obi_req_i,
  input  logic                   obi_we_i,
  input  logic [31:0]            obi_addr_i,
  input  logic [31:0]            obi_wdata_i,
  input  logic                   obi_gnt_i,
  input  logic                   obi_rvalid_i,
  input  logic [31:0]            obi_rdata_i,
  input  logic [GPIO_W-1:0]      gpio_in_i,
  input  logic [GPIO_W-1:0]      gpio_out_i,
  input  logic [GPIO_W-1:0]      gpio_en_i,
  input  logic [NUM_EXT_IRQ-1:0] irq_ext_i,
  input  logic                   irq_i,
  input  logic                   msip_i,
  output int                     err_count_o,
  output int                     check_count_o
);

  import periph_map_pkg::*;

  localparam int NUM_SRC = 1 + GPIO_W + NUM_EXT_IRQ;

  logic [GPIO_W-1:0]  s1_m;
  logic [GPIO_W-1:0]  s2_m;
  logic [GPIO_W-1:0]  s3_m;
  logic [GPIO_W-1:0]  out_m;
  logic [GPIO_W-1:0]  en_m;
  logic [GPIO_W-1:0]  ie_m;
  logic [GPIO_W-1:0]  is_m;
  logic [NUM_SRC-1:0] pend_m;
  logic [NUM_SRC-1:0] ena_m;
  logic               msip_m;
  logic               rvalid_m;
  logic [31:0]        rdata_m;
  logic               model_live = 1'b0;

  initial begin
    err_count_o   = 0;
    check_count_o = 0;
  end

  function automatic int lowest_id(input logic [NUM_SRC-1:0] act);
    int id;
    id = 0;
    for (int i = 1; i < NUM_SRC; i++) begin
      if (act[i] && id == 0) begin
        id = i;
      end
    end
    return id;
  endfunction

  function automatic logic [31:0] read_value(input logic [3:0] sel, input logic [5:0] off,
                                             input int id);
    logic [31:0] v;
    v = '0;
    if (sel == GPIO_IDX) begin
      case (off)
        GPIO_IN_OFF:  v = 32'(s2_m);
        GPIO_OUT_OFF: v = 32'(out_m);
        GPIO_EN_OFF:  v = 32'(en_m);
        GPIO_IE_OFF:  v = 32'(ie_m);
        GPIO_IS_OFF:  v = 32'(is_m);
        default:      v = '0;
      endcase
    end else if (sel == PLIC_IDX) begin
      case (off)
        PLIC_PEND_OFF:  v = 32'(pend_m);
        PLIC_ENA_OFF:   v = 32'(ena_m);
        PLIC_CLAIM_OFF: v = 32'(id);
        PLIC_MSIP_OFF:  v = {31'b0, msip_m};
        default:        v = '0;
      endcase
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count_o++;
    if (act !== exp) begin
      err_count_o++;
      $display("[FAIL] %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
    end
  endtask

  always @(posedge clk_i) begin : model_step
    logic [3:0]         sel;
    logic [5:0]         off;
    logic               rd_acc;
    logic               wr_acc;
    logic [NUM_SRC-1:0] src;
    logic [NUM_SRC-1:0] pend_n;
    logic [GPIO_W-1:0]  clr;
    logic [GPIO_W-1:0]  is_n;
    logic [31:0]        rd;
    int                 id;
    if (!rst_n_i) begin
      s1_m     = '0;
      s2_m     = '0;
      s3_m     = '0;
      out_m    = '0;
      en_m     = '0;
      ie_m     = '0;
      is_m     = '0;
      pend_m   = '0;
      ena_m    = '0;
      msip_m   = 1'b0;
      rvalid_m = 1'b0;
      rdata_m  = '0;
      model_live = 1'b1;
    end else begin
      sel    = obi_addr_i[11:8];
      off    = obi_addr_i[7:2];
      rd_acc = obi_req_i && !obi_we_i;
      wr_acc = obi_req_i && obi_we_i;
      // All next values come from the state before this edge
      src    = {irq_ext_i, is_m & ie_m, 1'b0};
      id     = lowest_id(pend_m & ena_m);
      rd     = rd_acc ? read_value(sel, off, id) : '0;
      pend_n = pend_m | src;
      if (rd_acc && sel == PLIC_IDX && off == PLIC_CLAIM_OFF && id != 0) begin
        pend_n[id] = 1'b0;
      end
      clr  = (wr_acc && sel == GPIO_IDX && off == GPIO_IS_OFF) ?
             obi_wdata_i[GPIO_W-1:0] : '0;
      is_n = (is_m & ~clr) | (s2_m & ~s3_m);
      s3_m   = s2_m;
      s2_m   = s1_m;
      s1_m   = gpio_in_i;
      pend_m = pend_n;
      is_m   = is_n;
      if (wr_acc && sel == GPIO_IDX) begin
        case (off)
          GPIO_OUT_OFF: out_m = obi_wdata_i[GPIO_W-1:0];
          GPIO_EN_OFF:  en_m  = obi_wdata_i[GPIO_W-1:0];
          GPIO_IE_OFF:  ie_m  = obi_wdata_i[GPIO_W-1:0];
          default: ;
        endcase
      end
      if (wr_acc && sel == PLIC_IDX) begin
        if (off == PLIC_ENA_OFF) begin
          ena_m    = obi_wdata_i[NUM_SRC-1:0];
          ena_m[0] = 1'b0;
        end else if (off == PLIC_MSIP_OFF) begin
          msip_m = obi_wdata_i[0];
        end
      end
      rvalid_m = obi_req_i;
      if (obi_req_i) begin
        rdata_m = rd;
      end
    end
  end

  // Outputs are all registered, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (model_live) begin
      check("obi_gnt_o", 32'd1, 32'(obi_gnt_i));
      check("obi_rvalid_o", 32'(rvalid_m), 32'(obi_rvalid_i));
      if (rvalid_m && obi_rvalid_i) begin
        check("obi_rdata_o", rdata_m, obi_rdata_i);
      end
      check("gpio_o", 32'(out_m), 32'(gpio_out_i));
      check("gpio_en_o", 32'(en_m), 32'(gpio_en_i));
      check("irq_o", 32'(|(pend_m & ena_m)), 32'(irq_i));
      check("msip_o", 32'(msip_m), 32'(msip_i));
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_peripheral_subsystem.sv
/*
 * Testbench for the peripheral subsystem: random OBI traffic and pin
 * stimulus, compared against a cycle model
 */
`timescale 1ns/1ps
`default_nettype none

module tb_peripheral_subsystem;

  import periph_map_pkg::*;

  localparam int GPIO_W      = 24;
  localparam int NUM_EXT_IRQ = 4;
  localparam int HALF_PERIOD = 20;
  localparam int TIMEOUT     = 20;

  logic                   clk;
  logic                   rst_n;
  logic                   obi_req;
  logic                   obi_we;
  logic [3:0]             obi_be;
  logic [31:0]            obi_addr;
  logic [31:0]            obi_wdata;
  logic                   obi_gnt;
  logic                   obi_rvalid;
  logic [31:0]            obi_rdata;
  logic [GPIO_W-1:0]      gpio_in;
  logic [GPIO_W-1:0]      gpio_out;
  logic [GPIO_W-1:0]      gpio_en;
  logic [NUM_EXT_IRQ-1:0] irq_ext;
  logic                   irq;
  logic                   msip;
  int                     err_count;
  int                     check_count;
  int                     fails_before;
  integer                 seed;
  logic [31:0]            data;
  logic [3:0]             sel;

  peripheral_subsystem #(
    .GPIO_W      (GPIO_W),
    .NUM_EXT_IRQ (NUM_EXT_IRQ)
  ) dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .obi_req_i    (obi_req),
    .obi_we_i     (obi_we),
    .obi_be_i     (obi_be),
    .obi_addr_i   (obi_addr),
    .obi_wdata_i  (obi_wdata),
    .obi_gnt_o    (obi_gnt),
    .obi_rvalid_o (obi_rvalid),
    .obi_rdata_o  (obi_rdata),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_en_o    (gpio_en),
    .irq_ext_i    (irq_ext),
    .irq_o        (irq),
    .msip_o       (msip)
  );

  subsystem_checker #(
    .GPIO_W      (GPIO_W),
    .NUM_EXT_IRQ (NUM_EXT_IRQ)
  ) checker_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .obi_req_i     (obi_req),
    .obi_we_i      (obi_we),
    .obi_addr_i    (obi_addr),
    .obi_wdata_i   (obi_wdata),
    .obi_gnt_i     (obi_gnt),
    .obi_rvalid_i  (obi_rvalid),
    .obi_rdata_i   (obi_rdata),
    .gpio_in_i     (gpio_in),
    .gpio_out_i    (gpio_out),
    .gpio_en_i     (gpio_en),
    .irq_ext_i     (irq_ext),
    .irq_i         (irq),
    .msip_i        (msip),
    .err_count_o   (err_count),
    .check_count_o (check_count)
  );

  always #HALF_PERIOD clk = ~clk;

  function automatic logic [31:0] mk_addr(input logic [3:0] s, input logic [5:0] off);
    return {20'h0, s, off, 2'b00};
  endfunction

  // Selects lean toward the two mapped peripherals
  function automatic logic [31:0] rand_addr();
    logic [31:0] r;
    logic [3:0]  s;
    r = $random(seed);
    if (r[2:0] < 3'd3) begin
      s = PLIC_IDX;
    end else if (r[2:0] < 3'd6) begin
      s = GPIO_IDX;
    end else begin
      s = r[7:4];
    end
    return {r[31:12], s, 3'b000, r[10:8], 2'b00};
  endfunction

  task automatic abort_run(input string why);
    $display("timeout: %s", why);
    $display("Errors found");
    $finish;
  endtask

  // Called on a falling edge, returns on the falling edge that holds rvalid
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
    int cycles;
    obi_req   = 1'b1;
    obi_we    = we;
    obi_addr  = addr;
    obi_wdata = wdata;
    cycles = 0;
    while (!obi_gnt && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!obi_gnt) begin
      abort_run("obi_gnt_o never went high");
    end
    @(negedge clk);
    obi_req = 1'b0;
    obi_we  = 1'b0;
    cycles = 0;
    while (!obi_rvalid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!obi_rvalid) begin
      abort_run("no obi_rvalid_o after a request");
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Counts are read after the checker has finished this falling edge
  task automatic report_test(input int num, input string name);
    @(posedge clk);
    if (err_count == fails_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: FAILED with %0d mismatches", num, name, err_count - fails_before);
    end
    fails_before = err_count;
    @(negedge clk);
  endtask

  initial begin
    seed         = 32'h918a;
    fails_before = 0;
    clk          = 1'b0;
    rst_n        = 1'b0;
    obi_req      = 1'b0;
    obi_we       = 1'b0;
    obi_be       = 4'hf;
    obi_addr     = '0;
    obi_wdata    = '0;
    gpio_in      = '0;
    irq_ext      = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    idle_cycles(3);
    report_test(1, "reset");

    for (int i = 0; i < 16; i++) begin
      data = $random(seed);
      bus_access(1'b1, mk_addr(GPIO_IDX, i[0] ? GPIO_EN_OFF : GPIO_OUT_OFF), data);
      bus_access(1'b0, mk_addr(GPIO_IDX, i[0] ? GPIO_EN_OFF : GPIO_OUT_OFF), '0);
    end
    report_test(2, "gpio outputs");

    bus_access(1'b1, mk_addr(PLIC_IDX, PLIC_ENA_OFF), 32'hffff_ffff);
    for (int i = 0; i < 12; i++) begin
      data = $random(seed);
      bus_access(1'b1, mk_addr(GPIO_IDX, GPIO_IE_OFF), data);
      data = $random(seed);
      gpio_in = data[GPIO_W-1:0];
      // Hold pins long enough to pass the synchroniser
      idle_cycles(4);
      bus_access(1'b0, mk_addr(GPIO_IDX, GPIO_IN_OFF), '0);
      bus_access(1'b0, mk_addr(GPIO_IDX, GPIO_IS_OFF), '0);
      bus_access(1'b0, mk_addr(PLIC_IDX, PLIC_PEND_OFF), '0);
      bus_access(1'b1, mk_addr(GPIO_IDX, GPIO_IS_OFF), $random(seed));
      bus_access(1'b0, mk_addr(GPIO_IDX, GPIO_IS_OFF), '0);
    end
    report_test(3, "gpio inputs");

    for (int i = 0; i < 16; i++) begin
      data = $random(seed);
      irq_ext = data[NUM_EXT_IRQ-1:0];
      gpio_in = data[GPIO_W+3:4];
      bus_access(1'b1, mk_addr(PLIC_IDX, PLIC_ENA_OFF), $random(seed));
      idle_cycles(2);
      repeat (3) bus_access(1'b0, mk_addr(PLIC_IDX, PLIC_CLAIM_OFF), '0);
      irq_ext = '0;
      idle_cycles(1);
      repeat (2) bus_access(1'b0, mk_addr(PLIC_IDX, PLIC_CLAIM_OFF), '0);
      bus_access(1'b0, mk_addr(PLIC_IDX, PLIC_PEND_OFF), '0);
    end
    report_test(4, "claim");

    for (int i = 0; i < 6; i++) begin
      bus_access(1'b1, mk_addr(PLIC_IDX, PLIC_MSIP_OFF), $random(seed));
      bus_access(1'b0, mk_addr(PLIC_IDX, PLIC_MSIP_OFF), '0);
    end
    for (int i = 0; i < 12; i++) begin
      data = $random(seed);
      sel = (data[3:0] < 4'd2) ? data[3:0] + 4'd2 : data[3:0];
      bus_access(1'b1, mk_addr(sel, data[9:4]), $random(seed));
      bus_access(1'b0, mk_addr(sel, data[9:4]), '0);
    end
    for (int i = 0; i < 40; i++) begin
      data = $random(seed);
      gpio_in = data[GPIO_W-1:0];
      bus_access(data[31], rand_addr(), $random(seed));
    end
    report_test(5, "msip and unmapped selects");

    idle_cycles(2);
    @(posedge clk);
    $display("tests: 5, checks: %0d, mismatches: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
verilog/periph_map_pkg.sv
verilog/irq_pkg.sv
verilog/periph_reg_bridge.sv
verilog/gpio_port.sv
verilog/plic_lite.sv
verilog/peripheral_subsystem.sv
verification/subsystem_checker.sv
verification/tb_peripheral_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_peripheral_subsystem
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
